//--- gpc_4t_consts.svh
// memory map, MMIO register offsets and memory depths
// for the gpc_4t memory side

`ifndef GPC_4T_CONSTS_SVH
`define GPC_4T_CONSTS_SVH

//====================================================================
// region bounds, byte addresses, msb is one past the last byte
//====================================================================
// data memory region
`define LSB_DATA_MEM         ('h0800)
`define MSB_DATA_MEM         ('h1000)

// MMIO region
`define LSB_MMIO_MEM         ('h1000)
`define MSB_MMIO_MEM         ('h1100)

//====================================================================
// MMIO register offsets
//====================================================================
// control register block base
`define OFFSET_MMIO_CSR      ('h1000)
// control registers relative to the CSR base
`define CSR_EN_PC_OFF        ('h0)
`define CSR_RST_PC_OFF       ('h4)
`define CSR_RD_PTR_OFF       ('h8)
`define CSR_START_OFF        ('h10)
`define CSR_DONE_OFF         ('h14)
// direct output register, full word
`define OFFSET_MMIO_DRCT_OUT ('h1080)

// word address widths, data mem is 512 words, instr mem 1024
`define D_MEM_WORDS_W        9
`define I_MEM_WORDS_W        10

`endif

//--- gpc_4t_pkg.sv
// shared vector types for the gpc_4t memory side
// words, byte addresses, byte enables, thread read pointer

package gpc_4t_pkg;

    // one data word on any port
    typedef logic [31:0] t_word;

    // byte address as issued by the core
    // word index is taken from bits above 1
    typedef logic [31:0] t_addr;

    // byte enables, bit n covers byte n of the word
    // byte n is bits 8n+7:8n
    typedef logic [3:0]  t_byteena;

    // thread read pointer in the control register
    // five bits, zero-extended on MMIO reads
    typedef logic [4:0]  t_rd_ptr;

    // byte lanes in a word
    localparam int unsigned BYTES_PER_WORD = 4;

    // width of a byte lane
    localparam int unsigned BYTE_W = 8;

endpackage

//--- d_mem.sv
// behavioral single-port memory
// byte-enabled write, registered read held between reads
`timescale 1ns/1ps

module d_mem #(
    parameter int WORDS_W = 9
) (
    input  logic                      clock,
    input  logic [WORDS_W-1:0]        address,
    input  gpc_4t_pkg::t_byteena      byteena,
    input  gpc_4t_pkg::t_word         data,
    input  logic                      rden,
    input  logic                      wren,
    output gpc_4t_pkg::t_word         q
);

    localparam int DEPTH = 2 ** WORDS_W;

    // storage, no reset on contents
    gpc_4t_pkg::t_word mem [0:DEPTH-1];

    //====================================================================
    // write port, one byte lane per enable bit
    //====================================================================
    always_ff @(posedge clock) begin
        if (wren) begin
            for (int i = 0; i < gpc_4t_pkg::BYTES_PER_WORD; i++) begin
                if (byteena[i]) begin
                    mem[address][i*gpc_4t_pkg::BYTE_W +: gpc_4t_pkg::BYTE_W] <=
                        data[i*gpc_4t_pkg::BYTE_W +: gpc_4t_pkg::BYTE_W];
                end
            end
        end
    end

    // registered read, q keeps the last read word
    always_ff @(posedge clock) begin
        if (rden) begin
            q <= mem[address];
        end
    end

    // single port, one access per cycle
    a_no_rd_wr_overlap: assert property (@(posedge clock) !(rden && wren))
        else $error("d_mem: rden and wren high together");

    // a write with no lanes enabled means a broken byteena path upstream
    a_wr_has_lanes: assert property (@(posedge clock) wren |-> (byteena != '0))
        else $error("d_mem: write with zero byte enables");

endmodule

//--- mmio_regs.sv
// MMIO control registers and direct output register
// write decode, zero-extended read mux, registered read
`timescale 1ns/1ps
`include "gpc_4t_consts.svh"

module mmio_regs (
    input  logic                  clock,
    input  logic                  rst,
    input  gpc_4t_pkg::t_addr     address,
    input  gpc_4t_pkg::t_byteena  byteena,
    input  gpc_4t_pkg::t_word     data,
    input  logic                  rden,
    input  logic                  wren,
    output gpc_4t_pkg::t_word     q,
    output logic                  en_pc,
    output logic                  rst_pc,
    output gpc_4t_pkg::t_rd_ptr   rd_ptr,
    output logic                  start,
    output logic                  done,
    output gpc_4t_pkg::t_word     drct_out
);

    // register select, one hot over the mapped offsets
    logic sel_en_pc;
    logic sel_rst_pc;
    logic sel_rd_ptr;
    logic sel_start;
    logic sel_done;
    logic sel_drct_out;

    // read value before the output flop
    gpc_4t_pkg::t_word rd_data;

    //====================================================================
    // address decode on the low 13 bits
    //====================================================================
    always_comb begin
        sel_en_pc    = (address[12:0] == 13'(`OFFSET_MMIO_CSR + `CSR_EN_PC_OFF));
        sel_rst_pc   = (address[12:0] == 13'(`OFFSET_MMIO_CSR + `CSR_RST_PC_OFF));
        sel_rd_ptr   = (address[12:0] == 13'(`OFFSET_MMIO_CSR + `CSR_RD_PTR_OFF));
        sel_start    = (address[12:0] == 13'(`OFFSET_MMIO_CSR + `CSR_START_OFF));
        sel_done     = (address[12:0] == 13'(`OFFSET_MMIO_CSR + `CSR_DONE_OFF));
        sel_drct_out = (address[12:0] == 13'(`OFFSET_MMIO_DRCT_OUT));
    end

    //====================================================================
    // register writes
    //====================================================================
    always_ff @(posedge clock) begin
        if (rst) begin
            en_pc    <= 1'b0;
            rst_pc   <= 1'b0;
            rd_ptr   <= '0;
            start    <= 1'b0;
            done     <= 1'b0;
            drct_out <= '0;
        end else if (wren) begin
            // single bit controls keep data bit 0 only
            if (sel_en_pc)  en_pc  <= data[0];
            if (sel_rst_pc) rst_pc <= data[0];
            if (sel_rd_ptr) rd_ptr <= data[4:0];
            // start is set by the SoC, cleared by the core
            if (sel_start)  start  <= data[0];
            // done goes the other way round
            if (sel_done)   done   <= data[0];
            // direct output takes bytes under the enables
            if (sel_drct_out) begin
                for (int i = 0; i < gpc_4t_pkg::BYTES_PER_WORD; i++) begin
                    if (byteena[i]) begin
                        drct_out[i*gpc_4t_pkg::BYTE_W +: gpc_4t_pkg::BYTE_W] <=
                            data[i*gpc_4t_pkg::BYTE_W +: gpc_4t_pkg::BYTE_W];
                    end
                end
            end
        end
    end

    // read mux, unmapped offsets give zero
    always_comb begin
        rd_data = '0;
        if (sel_en_pc)    rd_data = {31'b0, en_pc};
        if (sel_rst_pc)   rd_data = {31'b0, rst_pc};
        if (sel_rd_ptr)   rd_data = {27'b0, rd_ptr};
        if (sel_start)    rd_data = {31'b0, start};
        if (sel_done)     rd_data = {31'b0, done};
        if (sel_drct_out) rd_data = drct_out;
    end

    // synchronous read, held until the next read
    always_ff @(posedge clock) begin
        if (rden) begin
            q <= rd_data;
        end
    end

    a_mmio_no_rd_wr: assert property (@(posedge clock) disable iff (rst) !(rden && wren))
        else $error("mmio_regs: rden and wren high together");

endmodule

//--- d_mem_wrap.sv
// data memory wrapper
// region decode, data memory and MMIO blocks, sampled read-data mux
`timescale 1ns/1ps
`include "gpc_4t_consts.svh"

module d_mem_wrap (
    input  logic                  clock,
    input  logic                  rst,
    input  gpc_4t_pkg::t_addr     address,
    input  gpc_4t_pkg::t_byteena  byteena,
    input  gpc_4t_pkg::t_word     data,
    input  logic                  rden,
    input  logic                  wren,
    output gpc_4t_pkg::t_word     q,
    output logic                  en_pc,
    output logic                  rst_pc,
    output gpc_4t_pkg::t_rd_ptr   rd_ptr,
    output logic                  start,
    output logic                  done,
    output gpc_4t_pkg::t_word     drct_out
);

    logic              in_range_data;
    logic              in_range_mmio;
    // range flags of the last read pick the q source
    logic              smp_range_data;
    logic              smp_range_mmio;
    gpc_4t_pkg::t_addr offset_address;
    gpc_4t_pkg::t_word data_q;
    gpc_4t_pkg::t_word mmio_q;

    //====================================================================
    // region decode
    //====================================================================
    always_comb begin
        in_range_data  = (address >= `LSB_DATA_MEM) && (address < `MSB_DATA_MEM);
        in_range_mmio  = (address >= `LSB_MMIO_MEM) && (address < `MSB_MMIO_MEM);
        // data region starts at 'h800 so bit 11 is dropped for a zero based index
        offset_address     = address;
        offset_address[11] = 1'b0;
    end

    d_mem #(
        .WORDS_W (`D_MEM_WORDS_W)
    ) d_mem (
        .clock   (clock),
        .address (offset_address[`D_MEM_WORDS_W+1:2]),
        .byteena (byteena),
        .data    (data),
        .rden    (rden && in_range_data),
        .wren    (wren && in_range_data),
        .q       (data_q)
    );

    mmio_regs mmio_regs (
        .clock    (clock),
        .rst      (rst),
        .address  (address),
        .byteena  (byteena),
        .data     (data),
        .rden     (rden && in_range_mmio),
        .wren     (wren && in_range_mmio),
        .q        (mmio_q),
        .en_pc    (en_pc),
        .rst_pc   (rst_pc),
        .rd_ptr   (rd_ptr),
        .start    (start),
        .done     (done),
        .drct_out (drct_out)
    );

    // range flags sampled with each read and held between reads
    always_ff @(posedge clock) begin
        if (rst) begin
            smp_range_data <= 1'b0;
            smp_range_mmio <= 1'b0;
        end else if (rden) begin
            smp_range_data <= in_range_data;
            smp_range_mmio <= in_range_mmio;
        end
    end

    // memory, MMIO, or zero for an unmapped read
    assign q = smp_range_data ? data_q :
               smp_range_mmio ? mmio_q : '0;

    a_regions_disjoint: assert property (@(posedge clock) disable iff (rst)
        !(in_range_data && in_range_mmio))
        else $error("d_mem_wrap: address decodes to both regions");

endmodule

//--- gpc_4t_mem_top.sv
// memory side top level
// data memory wrapper plus instruction memory with loader port
`timescale 1ns/1ps
`include "gpc_4t_consts.svh"

module gpc_4t_mem_top (
    input  logic                  clock,
    input  logic                  rst,
    // core data port
    input  gpc_4t_pkg::t_addr     d_address,
    input  gpc_4t_pkg::t_byteena  d_byteena,
    input  gpc_4t_pkg::t_word     d_data,
    input  logic                  d_rden,
    input  logic                  d_wren,
    output gpc_4t_pkg::t_word     d_q,
    // fetch port
    input  gpc_4t_pkg::t_addr     pc,
    input  logic                  i_rden,
    output gpc_4t_pkg::t_word     instr_q,
    // loader port
    input  gpc_4t_pkg::t_addr     ld_address,
    input  gpc_4t_pkg::t_word     ld_data,
    input  logic                  ld_wren,
    // chip level controls
    output logic                  en_pc,
    output logic                  rst_pc,
    output gpc_4t_pkg::t_rd_ptr   rd_ptr,
    output logic                  start,
    output logic                  done,
    output gpc_4t_pkg::t_word     drct_out
);

    // instr memory only takes whole words
    gpc_4t_pkg::t_byteena          i_byteena;
    logic [`I_MEM_WORDS_W-1:0]     i_word_addr;

    assign i_byteena = '1;
    // loader owns the address while it writes
    assign i_word_addr = ld_wren ? ld_address[`I_MEM_WORDS_W+1:2]
                                 : pc[`I_MEM_WORDS_W+1:2];

    d_mem_wrap d_mem_wrap (
        .clock    (clock),    .rst      (rst),
        .address  (d_address), .byteena (d_byteena),
        .data     (d_data),   .rden     (d_rden),
        .wren     (d_wren),   .q        (d_q),
        .en_pc    (en_pc),    .rst_pc   (rst_pc),
        .rd_ptr   (rd_ptr),   .start    (start),
        .done     (done),     .drct_out (drct_out)
    );

    d_mem #(.WORDS_W (`I_MEM_WORDS_W)) i_mem (
        .clock (clock), .address (i_word_addr), .byteena (i_byteena),
        .data  (ld_data), .rden (i_rden), .wren (ld_wren), .q (instr_q)
    );

endmodule

//--- tb_gpc_4t_mem_top.sv
// directed testbench for the gpc_4t memory top level
// reference model of both memories and the MMIO registers, compare tasks, watchdog
`timescale 1ns/1ps
`include "gpc_4t_consts.svh"

module tb_gpc_4t_mem_top;

    localparam int CLK_PERIOD = 8;
    localparam int N_DATA     = 12;
    localparam int N_INSTR    = 12;
    // summed cycle budget of reset and the six tests
    localparam int TOTAL_CYCLES = 10 + 20 + 90 + 40 + 70 + 70 + 80;

    logic                  clock = 1'b0;
    logic                  rst;
    gpc_4t_pkg::t_addr     d_address;
    gpc_4t_pkg::t_byteena  d_byteena;
    gpc_4t_pkg::t_word     d_data;
    logic                  d_rden;
    logic                  d_wren;
    gpc_4t_pkg::t_word     d_q;
    gpc_4t_pkg::t_addr     pc;
    logic                  i_rden;
    gpc_4t_pkg::t_word     instr_q;
    gpc_4t_pkg::t_addr     ld_address;
    gpc_4t_pkg::t_word     ld_data;
    logic                  ld_wren;
    logic                  en_pc;
    logic                  rst_pc;
    gpc_4t_pkg::t_rd_ptr   rd_ptr;
    logic                  start;
    logic                  done;
    gpc_4t_pkg::t_word     drct_out;

    //====================================================================
    // reference model state
    //====================================================================
    gpc_4t_pkg::t_word   dmem_model [gpc_4t_pkg::t_addr];
    gpc_4t_pkg::t_word   imem_model [gpc_4t_pkg::t_addr];
    logic                sh_en_pc;
    logic                sh_rst_pc;
    logic                sh_start;
    logic                sh_done;
    gpc_4t_pkg::t_rd_ptr sh_rd_ptr;
    gpc_4t_pkg::t_word   sh_drct_out;
    // addresses in use and the list for streamed reads
    gpc_4t_pkg::t_addr   data_addrs [$];
    gpc_4t_pkg::t_addr   instr_addrs [$];
    gpc_4t_pkg::t_addr   mmio_addrs [$];
    gpc_4t_pkg::t_addr   rd_list [$];

    int errors = 0;
    int checks = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    gpc_4t_mem_top i_gpc_4t_mem_top (
        .clock (clock), .rst (rst),
        .d_address (d_address), .d_byteena (d_byteena), .d_data (d_data),
        .d_rden (d_rden), .d_wren (d_wren), .d_q (d_q),
        .pc (pc), .i_rden (i_rden), .instr_q (instr_q),
        .ld_address (ld_address), .ld_data (ld_data), .ld_wren (ld_wren),
        .en_pc (en_pc), .rst_pc (rst_pc), .rd_ptr (rd_ptr),
        .start (start), .done (done), .drct_out (drct_out)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    //====================================================================
    // compare tasks
    //====================================================================
    task automatic check_word(string name, gpc_4t_pkg::t_word exp, gpc_4t_pkg::t_word act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_rd_ptr(string name, gpc_4t_pkg::t_rd_ptr exp,
                                gpc_4t_pkg::t_rd_ptr act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    //====================================================================
    // model functions
    //====================================================================
    function automatic logic in_data_region(gpc_4t_pkg::t_addr a);
        return (a >= `LSB_DATA_MEM) && (a < `MSB_DATA_MEM);
    endfunction

    function automatic logic in_mmio_region(gpc_4t_pkg::t_addr a);
        return (a >= `LSB_MMIO_MEM) && (a < `MSB_MMIO_MEM);
    endfunction

    // byte n of the new word replaces byte n of the old one when enabled
    function automatic gpc_4t_pkg::t_word merge_bytes(gpc_4t_pkg::t_word old_w,
            gpc_4t_pkg::t_word new_w, gpc_4t_pkg::t_byteena be);
        gpc_4t_pkg::t_word res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
        end
        return res;
    endfunction

    // what a data port read of this address should give
    function automatic gpc_4t_pkg::t_word expect_d(gpc_4t_pkg::t_addr a);
        if (in_data_region(a)) return dmem_model[a];
        if (!in_mmio_region(a)) return '0;
        if (a == `OFFSET_MMIO_CSR + `CSR_EN_PC_OFF)  return {31'b0, sh_en_pc};
        if (a == `OFFSET_MMIO_CSR + `CSR_RST_PC_OFF) return {31'b0, sh_rst_pc};
        if (a == `OFFSET_MMIO_CSR + `CSR_RD_PTR_OFF) return {27'b0, sh_rd_ptr};
        if (a == `OFFSET_MMIO_CSR + `CSR_START_OFF)  return {31'b0, sh_start};
        if (a == `OFFSET_MMIO_CSR + `CSR_DONE_OFF)   return {31'b0, sh_done};
        if (a == `OFFSET_MMIO_DRCT_OUT)              return sh_drct_out;
        return '0;
    endfunction

    task automatic apply_write(gpc_4t_pkg::t_addr a, gpc_4t_pkg::t_byteena be,
                               gpc_4t_pkg::t_word d);
        if (in_data_region(a)) begin
            dmem_model[a] = merge_bytes(dmem_model.exists(a) ? dmem_model[a] : '0, d, be);
        end else if (in_mmio_region(a)) begin
            if (a == `OFFSET_MMIO_CSR + `CSR_EN_PC_OFF)  sh_en_pc = d[0];
            if (a == `OFFSET_MMIO_CSR + `CSR_RST_PC_OFF) sh_rst_pc = d[0];
            if (a == `OFFSET_MMIO_CSR + `CSR_RD_PTR_OFF) sh_rd_ptr = d[4:0];
            if (a == `OFFSET_MMIO_CSR + `CSR_START_OFF)  sh_start = d[0];
            if (a == `OFFSET_MMIO_CSR + `CSR_DONE_OFF)   sh_done = d[0];
            if (a == `OFFSET_MMIO_DRCT_OUT) sh_drct_out = merge_bytes(sh_drct_out, d, be);
        end
    endtask

    task automatic clear_shadows();
        sh_en_pc = 1'b0;
        sh_rst_pc = 1'b0;
        sh_rd_ptr = '0;
        sh_start = 1'b0;
        sh_done = 1'b0;
        sh_drct_out = '0;
    endtask

    //====================================================================
    // bus operations
    //====================================================================
    task automatic check_outputs();
        check_bit("en_pc", sh_en_pc, en_pc);
        check_bit("rst_pc", sh_rst_pc, rst_pc);
        check_rd_ptr("rd_ptr", sh_rd_ptr, rd_ptr);
        check_bit("start", sh_start, start);
        check_bit("done", sh_done, done);
        check_word("drct_out", sh_drct_out, drct_out);
    endtask

    // outputs hold during the strobe cycle and follow the write one cycle later
    task automatic d_write(gpc_4t_pkg::t_addr a, gpc_4t_pkg::t_byteena be,
                           gpc_4t_pkg::t_word d);
        @(posedge clock);
        d_address <= a;
        d_byteena <= be;
        d_data <= d;
        d_wren <= 1'b1;
        @(negedge clock);
        check_outputs();
        @(posedge clock);
        d_wren <= 1'b0;
        apply_write(a, be, d);
        @(negedge clock);
        check_outputs();
    endtask

    // back-to-back reads of rd_list with each result checked the cycle after its strobe
    task automatic read_stream();
        for (int i = 0; i < rd_list.size(); i++) begin
            @(posedge clock);
            d_address <= rd_list[i];
            d_rden <= 1'b1;
            @(negedge clock);
            if (i > 0) begin
                check_word($sformatf("d_q @%h", rd_list[i-1]), expect_d(rd_list[i-1]), d_q);
            end
        end
        @(posedge clock);
        d_rden <= 1'b0;
        @(negedge clock);
        if (rd_list.size() > 0) begin
            check_word($sformatf("d_q @%h", rd_list[$]), expect_d(rd_list[$]), d_q);
        end
    endtask

    task automatic load_word(gpc_4t_pkg::t_addr a, gpc_4t_pkg::t_word d);
        @(posedge clock);
        ld_address <= a;
        ld_data <= d;
        ld_wren <= 1'b1;
        @(posedge clock);
        ld_wren <= 1'b0;
        imem_model[a] = d;
    endtask

    // fetch and data read issued in the same cycle
    task automatic fetch_and_read(gpc_4t_pkg::t_addr pa, gpc_4t_pkg::t_addr da);
        @(posedge clock);
        pc <= pa;
        i_rden <= 1'b1;
        d_address <= da;
        d_rden <= 1'b1;
        @(posedge clock);
        i_rden <= 1'b0;
        d_rden <= 1'b0;
        @(negedge clock);
        check_word($sformatf("instr_q @%h", pa), imem_model[pa], instr_q);
        check_word($sformatf("d_q @%h", da), expect_d(da), d_q);
    endtask

    task automatic report_test(string name, int err0);
        if (errors == err0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d mismatches", name, errors - err0);
        end
    endtask

    //====================================================================
    // tests
    //====================================================================
    task automatic test_reset_state();
        int err0;
        err0 = errors;
        check_outputs();
        rd_list = mmio_addrs;
        // unmapped offset inside the MMIO region
        rd_list.push_back(32'h100c);
        read_stream();
        report_test("reset state", err0);
    endtask

    task automatic test_data_mem();
        int err0;
        gpc_4t_pkg::t_addr a;
        gpc_4t_pkg::t_byteena be;
        err0 = errors;
        // full words first so every byte is known
        for (int i = 0; i < N_DATA; i++) begin
            a = gpc_4t_pkg::t_addr'(`LSB_DATA_MEM + ($urandom % 512) * 4);
            data_addrs.push_back(a);
            d_write(a, 4'hf, $urandom);
        end
        for (int i = 0; i < N_DATA; i++) begin
            a = data_addrs[$urandom % N_DATA];
            be = gpc_4t_pkg::t_byteena'($urandom % 15 + 1);
            d_write(a, be, $urandom);
        end
        rd_list = data_addrs;
        read_stream();
        report_test("data memory", err0);
    endtask

    task automatic test_mmio_regs();
        int err0;
        err0 = errors;
        // bit 0 set so every control register leaves its reset value
        for (int i = 0; i < 5; i++) begin
            d_write(mmio_addrs[i], 4'hf, $urandom | 32'h1);
        end
        d_write(`OFFSET_MMIO_DRCT_OUT, gpc_4t_pkg::t_byteena'($urandom % 15 + 1), $urandom);
        rd_list = mmio_addrs;
        read_stream();
        report_test("mmio registers", err0);
    endtask

    task automatic test_region_select();
        int err0;
        gpc_4t_pkg::t_addr hi_gap;
        gpc_4t_pkg::t_addr lo_gap;
        err0 = errors;
        // gap addresses alias the word index of a written data address
        lo_gap = data_addrs[0] - `LSB_DATA_MEM;
        hi_gap = gpc_4t_pkg::t_addr'(`MSB_MMIO_MEM + ($urandom % 'h700) / 4 * 4);
        foreach (data_addrs[i]) begin
            if ((data_addrs[i] & 'h700) != 0) begin
                hi_gap = `LSB_MMIO_MEM | (data_addrs[i] & 'h7fc);
            end
        end
        // q source flips every cycle
        rd_list.delete();
        for (int i = 0; i < 6; i++) begin
            rd_list.push_back(data_addrs[i]);
            rd_list.push_back(mmio_addrs[i]);
        end
        rd_list.push_back(hi_gap);
        rd_list.push_back(data_addrs[6]);
        rd_list.push_back(lo_gap);
        rd_list.push_back(mmio_addrs[0]);
        read_stream();
        // writes to the gaps land nowhere
        d_write(hi_gap, 4'hf, $urandom);
        d_write(lo_gap, 4'hf, $urandom);
        rd_list = data_addrs;
        rd_list = {rd_list, mmio_addrs};
        read_stream();
        report_test("region select", err0);
    endtask

    task automatic test_instr_mem();
        int err0;
        gpc_4t_pkg::t_addr a;
        err0 = errors;
        for (int i = 0; i < N_INSTR; i++) begin
            a = gpc_4t_pkg::t_addr'(($urandom % 1024) * 4);
            instr_addrs.push_back(a);
            load_word(a, $urandom);
        end
        for (int i = 0; i < N_INSTR; i++) begin
            fetch_and_read(instr_addrs[i], (i % 2 == 0) ? data_addrs[i] : mmio_addrs[i % 6]);
        end
        report_test("instruction memory", err0);
    endtask

    task automatic test_mid_reset();
        int err0;
        err0 = errors;
        d_write(`OFFSET_MMIO_CSR + `CSR_EN_PC_OFF, 4'hf, 32'h1);
        d_write(`OFFSET_MMIO_CSR + `CSR_RD_PTR_OFF, 4'hf, 32'h1f);
        d_write(`OFFSET_MMIO_CSR + `CSR_DONE_OFF, 4'hf, 32'h1);
        d_write(`OFFSET_MMIO_DRCT_OUT, 4'hf, $urandom | 32'h1);
        @(posedge clock);
        rst <= 1'b1;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        clear_shadows();
        @(negedge clock);
        check_outputs();
        // memories keep their contents through reset
        rd_list = mmio_addrs;
        rd_list = {rd_list, data_addrs};
        read_stream();
        for (int i = 0; i < N_INSTR; i++) begin
            fetch_and_read(instr_addrs[i], data_addrs[N_DATA - 1 - i]);
        end
        report_test("reset during use", err0);
    endtask

    //====================================================================
    // main sequence
    //====================================================================
    initial begin
        void'($urandom(32'hf569_4aef));
        rst = 1'b1;
        d_address = '0;
        d_byteena = '0;
        d_data = '0;
        d_rden = 1'b0;
        d_wren = 1'b0;
        pc = '0;
        i_rden = 1'b0;
        ld_address = '0;
        ld_data = '0;
        ld_wren = 1'b0;
        clear_shadows();
        mmio_addrs = '{`OFFSET_MMIO_CSR + `CSR_EN_PC_OFF, `OFFSET_MMIO_CSR + `CSR_RST_PC_OFF,
                       `OFFSET_MMIO_CSR + `CSR_RD_PTR_OFF, `OFFSET_MMIO_CSR + `CSR_START_OFF,
                       `OFFSET_MMIO_CSR + `CSR_DONE_OFF, `OFFSET_MMIO_DRCT_OUT};
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        test_reset_state();
        test_data_mem();
        test_mmio_regs();
        test_region_select();
        test_instr_mem();
        test_mid_reset();
        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d mismatches",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog ends a stuck run
    initial begin
        #(TOTAL_CYCLES * 2 * CLK_PERIOD);
        $display("watchdog: tests did not finish within %0d ns",
                 TOTAL_CYCLES * 2 * CLK_PERIOD);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- all.f
+incdir+.
gpc_4t_pkg.sv
d_mem.sv
mmio_regs.sv
d_mem_wrap.sv
gpc_4t_mem_top.sv
tb_gpc_4t_mem_top.sv

//--- Makefile
# Verilator build, run, lint and clean for the gpc_4t memory side

VERILATOR ?= verilator
TOP       ?= tb_gpc_4t_mem_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
